//--- Bender.yml
package:
  name: conv_accel

sources:
  - design/convPkg.sv
  - design/convWindowScan.sv
  - design/convBankedMemory.sv
  - design/convMacUnit.sv
  - design/convOutFifo.sv
  - design/convAccelTop.sv
  - target: test
    files:
      - test/convAccelTb.sv

//--- build.f
design/convPkg.sv
design/convWindowScan.sv
design/convBankedMemory.sv
design/convMacUnit.sv
design/convOutFifo.sv
design/convAccelTop.sv
test/convAccelTb.sv

//--- design/convAccelTop.sv
`timescale 1ns/1ps

module convAccelTop
    import convPkg::*;
#(
    parameter int FIFO_DEPTH = 32,
    parameter int FIFO_SKID = 8
) (
    input  logic     clkIn,
    input  logic     rstIn,
    input  busWriteT busWrite,
    input  logic     startIn,
    input  dimsT     dims,
    input  logic     readyIn,
    output logic     validOut,
    output accT      dataOut
);

    readReqT  readReq;
    laneDataT laneData;
    logic     macValid;
    accT      macData;
    logic     stall;
    logic     inFlight;

    // Steps between scanner and MAC that the FIFO cannot count
    assign inFlight = readReq.valid | laneData.valid;

    convWindowScan scan (
        .clkIn   (clkIn),
        .rstIn   (rstIn),
        .startIn (startIn),
        .dims    (dims),
        .stall   (stall),
        .readReq (readReq)
    );

    convBankedMemory mem (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .busWrite (busWrite),
        .readReq  (readReq),
        .laneData (laneData)
    );

    convMacUnit mac (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .laneData (laneData),
        .macValid (macValid),
        .macData  (macData)
    );

    convOutFifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_SKID  (FIFO_SKID)
    ) outFifo (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .wrValid  (macValid),
        .wrData   (macData),
        .inFlight (inFlight),
        .readyIn  (readyIn),
        .stall    (stall),
        .validOut (validOut),
        .dataOut  (dataOut)
    );

endmodule

//--- design/convBankedMemory.sv
`timescale 1ns/1ps

module convBankedMemory
    import convPkg::*;
(
    input  logic     clkIn,
    input  logic     rstIn,
    input  busWriteT busWrite,
    input  readReqT  readReq,
    output laneDataT laneData
);

    elemT dataBank [VEC_LANES][BANK_DEPTH];
    elemT filtBank [VEC_LANES][BANK_DEPTH];

    // Bank read stage
    laneVecT                   dataRdR;
    laneVecT                   filtRdR;
    logic [LANE_IDX_WIDTH-1:0] dataShiftR;
    logic [LANE_IDX_WIDTH-1:0] filtShiftR;
    logic [VEC_LANES-1:0]      maskR;
    logic                      lastR;
    logic                      validR;

    // Row of a bank when a vector starts at element start
    function automatic logic [BANK_ADDR_WIDTH-1:0] bankRow(
        input logic [ELEM_ADDR_WIDTH-1:0] start,
        input int bank
    );
        logic [LANE_IDX_WIDTH-1:0]  lane;
        logic [ELEM_ADDR_WIDTH-1:0] elemAddr;
        lane = LANE_IDX_WIDTH'(bank) - start[LANE_IDX_WIDTH-1:0];
        elemAddr = start + ELEM_ADDR_WIDTH'(lane);
        return elemAddr[ELEM_ADDR_WIDTH-1:LANE_IDX_WIDTH];
    endfunction

    // Bank order to lane order
    function automatic laneVecT rotateLanes(
        input laneVecT banks,
        input logic [LANE_IDX_WIDTH-1:0] shift
    );
        laneVecT                   lanes;
        logic [LANE_IDX_WIDTH-1:0] bank;
        for (int j = 0; j < VEC_LANES; j++) begin
            bank = LANE_IDX_WIDTH'(j) + shift;
            lanes[j*ELEM_WIDTH +: ELEM_WIDTH] = banks[bank*ELEM_WIDTH +: ELEM_WIDTH];
        end
        return lanes;
    endfunction

    // Bus writes and bank reads
    always_ff @(posedge clkIn) begin
        for (int b = 0; b < VEC_LANES; b++) begin
            if (busWrite.wrEn[b]) begin
                if (busWrite.isFilt) begin
                    filtBank[b][busWrite.rowAddr] <= busWrite.data[b*ELEM_WIDTH +: ELEM_WIDTH];
                end else begin
                    dataBank[b][busWrite.rowAddr] <= busWrite.data[b*ELEM_WIDTH +: ELEM_WIDTH];
                end
            end
            dataRdR[b*ELEM_WIDTH +: ELEM_WIDTH] <= dataBank[b][bankRow(readReq.dataAddr, b)];
            filtRdR[b*ELEM_WIDTH +: ELEM_WIDTH] <= filtBank[b][bankRow(readReq.filtAddr, b)];
        end
        dataShiftR <= readReq.dataAddr[LANE_IDX_WIDTH-1:0];
        filtShiftR <= readReq.filtAddr[LANE_IDX_WIDTH-1:0];
        maskR <= readReq.laneMask;
        lastR <= readReq.last;
    end

    // Rotation stage
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            validR <= 1'b0;
            laneData.valid <= 1'b0;
        end else begin
            validR <= readReq.valid;
            laneData.valid <= validR;
        end
        laneData.dataLanes <= rotateLanes(dataRdR, dataShiftR);
        laneData.filtLanes <= rotateLanes(filtRdR, filtShiftR);
        laneData.laneMask <= maskR;
        laneData.last <= lastR;
    end

endmodule

//--- design/convMacUnit.sv
`timescale 1ns/1ps

module convMacUnit
    import convPkg::*;
(
    input  logic     clkIn,
    input  logic     rstIn,
    input  laneDataT laneData,
    output logic     macValid,
    output accT      macData
);

    accT accR;
    accT beatSum;

    // Sum of masked lane products, wraps at ACC_WIDTH
    always_comb begin
        beatSum = '0;
        for (int j = 0; j < VEC_LANES; j++) begin
            if (laneData.laneMask[j]) begin
                beatSum += accT'(elemT'(laneData.dataLanes[j*ELEM_WIDTH +: ELEM_WIDTH])) *
                           accT'(elemT'(laneData.filtLanes[j*ELEM_WIDTH +: ELEM_WIDTH]));
            end
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            accR <= '0;
            macValid <= 1'b0;
        end else begin
            macValid <= laneData.valid && laneData.last;
            if (laneData.valid) begin
                // Restart from zero after the window's last beat
                accR <= laneData.last ? '0 : accR + beatSum;
            end
        end
        if (laneData.valid && laneData.last) begin
            macData <= accR + beatSum;
        end
    end

endmodule

//--- design/convOutFifo.sv
`timescale 1ns/1ps

module convOutFifo
    import convPkg::*;
#(
    parameter int FIFO_DEPTH = 32,
    parameter int FIFO_SKID = 8
) (
    input  logic clkIn,
    input  logic rstIn,
    input  logic wrValid,
    input  accT  wrData,
    input  logic inFlight,
    input  logic readyIn,
    output logic stall,
    output logic validOut,
    output accT  dataOut
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    localparam logic [CNT_WIDTH-1:0] STALL_LEVEL = CNT_WIDTH'(FIFO_DEPTH - FIFO_SKID);

    accT                  mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wrPtr;
    logic [PTR_WIDTH-1:0] rdPtr;
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] level;
    logic                 outLoad;
    logic                 bypass;
    logic                 push;
    logic                 pop;

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Output register is free or being drained this cycle
    assign outLoad = !validOut || readyIn;
    // Empty buffer hands a new result straight to the output
    assign bypass = outLoad && (count == '0) && wrValid;
    assign pop = outLoad && (count != '0);
    assign push = wrValid && !bypass;

    // Occupancy plus results still on their way
    assign level = count + CNT_WIDTH'(wrValid) + CNT_WIDTH'(inFlight);

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            validOut <= 1'b0;
            stall <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + CNT_WIDTH'(push) - CNT_WIDTH'(pop);
            if (outLoad) begin
                validOut <= pop || bypass;
            end
            stall <= (level >= STALL_LEVEL);
        end
    end

    always_ff @(posedge clkIn) begin
        if (push) begin
            mem[wrPtr] <= wrData;
        end
        if (pop) begin
            dataOut <= mem[rdPtr];
        end else if (bypass) begin
            dataOut <= wrData;
        end
    end

endmodule

//--- design/convPkg.sv
package convPkg;

    // Element and result widths
    localparam int ELEM_WIDTH = 16;
    localparam int ACC_WIDTH = 32;

    // Vector width equals the number of banks per region
    localparam int VEC_LANES = 4;
    localparam int LANE_IDX_WIDTH = $clog2(VEC_LANES);

    // Matrix storage, 16 by 16 at most
    localparam int MAX_ELEMS = 256;
    localparam int BANK_DEPTH = MAX_ELEMS / VEC_LANES;
    localparam int ELEM_ADDR_WIDTH = $clog2(MAX_ELEMS);
    localparam int BANK_ADDR_WIDTH = $clog2(BANK_DEPTH);
    localparam int DIM_WIDTH = 5;

    // One bus word carries one element per lane
    localparam int BUS_DATA_WIDTH = VEC_LANES * ELEM_WIDTH;

    typedef logic signed [ELEM_WIDTH-1:0] elemT;
    typedef logic signed [ACC_WIDTH-1:0] accT;
    typedef logic [BUS_DATA_WIDTH-1:0] laneVecT;

    typedef struct packed {
        logic [DIM_WIDTH-1:0] filtRows;
        logic [DIM_WIDTH-1:0] filtCols;
        logic [DIM_WIDTH-1:0] dataRows;
        logic [DIM_WIDTH-1:0] dataCols;
    } dimsT;

    typedef struct packed {
        logic [VEC_LANES-1:0]       wrEn;
        logic                       isFilt;
        logic [BANK_ADDR_WIDTH-1:0] rowAddr;
        laneVecT                    data;
    } busWriteT;

    // One read step, scanner to memory
    typedef struct packed {
        logic [ELEM_ADDR_WIDTH-1:0] dataAddr;
        logic [ELEM_ADDR_WIDTH-1:0] filtAddr;
        logic [VEC_LANES-1:0]       laneMask;
        logic                       last;
        logic                       valid;
    } readReqT;

    // Lane-aligned read result, memory to MAC
    typedef struct packed {
        laneVecT              dataLanes;
        laneVecT              filtLanes;
        logic [VEC_LANES-1:0] laneMask;
        logic                 last;
        logic                 valid;
    } laneDataT;

endpackage

//--- design/convWindowScan.sv
`timescale 1ns/1ps

module convWindowScan
    import convPkg::*;
(
    input  logic    clkIn,
    input  logic    rstIn,
    input  logic    startIn,
    input  dimsT    dims,
    input  logic    stall,
    output readReqT readReq
);

    // Run state and geometry latched at start
    logic                 running;
    logic [DIM_WIDTH-1:0] filtColsR;
    logic [DIM_WIDTH-1:0] dataColsR;
    logic [DIM_WIDTH-1:0] vecMaxR;
    logic [DIM_WIDTH-1:0] filtRowMaxR;
    logic [DIM_WIDTH-1:0] dataColMaxR;
    logic [DIM_WIDTH-1:0] dataRowMaxR;
    logic [VEC_LANES-1:0] tailMaskR;

    // Window counters, innermost first
    logic [DIM_WIDTH-1:0] vecCnt;
    logic [DIM_WIDTH-1:0] filtRowCnt;
    logic [DIM_WIDTH-1:0] dataColCnt;
    logic [DIM_WIDTH-1:0] dataRowCnt;

    logic [DIM_WIDTH-1:0]       filtVecs;
    logic [VEC_LANES-1:0]       tailMask;
    logic                       lastVec;
    logic                       lastFiltRow;
    logic                       lastDataCol;
    logic                       lastDataRow;
    logic [ELEM_ADDR_WIDTH-1:0] vecOffset;
    logic [ELEM_ADDR_WIDTH-1:0] dataRowAddr;
    logic [ELEM_ADDR_WIDTH-1:0] filtRowAddr;

    // Vectors per filter row, rounded up
    assign filtVecs = (dims.filtCols + DIM_WIDTH'(VEC_LANES - 1)) >> LANE_IDX_WIDTH;

    // Lanes still inside the row on its final vector
    always_comb begin
        for (int j = 0; j < VEC_LANES; j++) begin
            tailMask[j] = (dims.filtCols[LANE_IDX_WIDTH-1:0] == '0) ||
                          (LANE_IDX_WIDTH'(j) < dims.filtCols[LANE_IDX_WIDTH-1:0]);
        end
    end

    assign lastVec = (vecCnt == vecMaxR);
    assign lastFiltRow = (filtRowCnt == filtRowMaxR);
    assign lastDataCol = (dataColCnt == dataColMaxR);
    assign lastDataRow = (dataRowCnt == dataRowMaxR);

    // Flat start addresses of the current step
    always_comb begin
        vecOffset = ELEM_ADDR_WIDTH'(vecCnt) << LANE_IDX_WIDTH;
        dataRowAddr = (ELEM_ADDR_WIDTH'(dataRowCnt) + ELEM_ADDR_WIDTH'(filtRowCnt)) *
                      ELEM_ADDR_WIDTH'(dataColsR);
        filtRowAddr = ELEM_ADDR_WIDTH'(filtRowCnt) * ELEM_ADDR_WIDTH'(filtColsR);

        readReq.dataAddr = dataRowAddr + ELEM_ADDR_WIDTH'(dataColCnt) + vecOffset;
        readReq.filtAddr = filtRowAddr + vecOffset;
        readReq.laneMask = lastVec ? tailMaskR : '1;
        readReq.last = lastVec && lastFiltRow;
        readReq.valid = running && !stall;
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            running <= 1'b0;
            filtColsR <= '0;
            dataColsR <= '0;
            vecMaxR <= '0;
            filtRowMaxR <= '0;
            dataColMaxR <= '0;
            dataRowMaxR <= '0;
            tailMaskR <= '0;
            vecCnt <= '0;
            filtRowCnt <= '0;
            dataColCnt <= '0;
            dataRowCnt <= '0;
        end else if (!running) begin
            if (startIn) begin
                running <= 1'b1;
                filtColsR <= dims.filtCols;
                dataColsR <= dims.dataCols;
                vecMaxR <= filtVecs - 1'b1;
                filtRowMaxR <= dims.filtRows - 1'b1;
                dataColMaxR <= dims.dataCols - dims.filtCols;
                dataRowMaxR <= dims.dataRows - dims.filtRows;
                tailMaskR <= tailMask;
            end
        end else if (!stall) begin
            if (!lastVec) begin
                vecCnt <= vecCnt + 1'b1;
            end else begin
                vecCnt <= '0;
                if (!lastFiltRow) begin
                    filtRowCnt <= filtRowCnt + 1'b1;
                end else begin
                    filtRowCnt <= '0;
                    if (!lastDataCol) begin
                        dataColCnt <= dataColCnt + 1'b1;
                    end else begin
                        dataColCnt <= '0;
                        if (!lastDataRow) begin
                            dataRowCnt <= dataRowCnt + 1'b1;
                        end else begin
                            // Final step of the final window
                            dataRowCnt <= '0;
                            running <= 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- test/convAccelTb.sv
`timescale 1ns/1ps

module convAccelTb
    import convPkg::*;
();

    localparam int RUN_TIMEOUT = 20000;
    localparam int QUIET_CYCLES = 20;

    logic     clkIn = 1'b0;
    logic     rstIn;
    busWriteT busWrite;
    logic     startIn;
    dimsT     dims;
    logic     readyIn;
    logic     validOut;
    accT      dataOut;

    // Model copy of both regions by flat element address
    elemT dataModel [MAX_ELEMS];
    elemT filtModel [MAX_ELEMS];
    accT  expQ [$];

    int errors = 0;
    int testErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    bit timedOut = 1'b0;

    convAccelTop #(
        .FIFO_DEPTH (32),
        .FIFO_SKID  (8)
    ) dut_i (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .busWrite (busWrite),
        .startIn  (startIn),
        .dims     (dims),
        .readyIn  (readyIn),
        .validOut (validOut),
        .dataOut  (dataOut)
    );

    always #4 clkIn = ~clkIn;

    // Drives one bus word of random elements and mirrors its enabled lanes in the model
    task automatic writeWord(input bit isFilt, input int row, input logic [VEC_LANES-1:0] en);
        busWriteT w;
        elemT     v;
        w.wrEn = en;
        w.isFilt = isFilt;
        w.rowAddr = BANK_ADDR_WIDTH'(row);
        for (int i = 0; i < VEC_LANES; i++) begin
            v = elemT'($urandom);
            w.data[i*ELEM_WIDTH +: ELEM_WIDTH] = v;
            if (en[i] && isFilt) begin
                filtModel[row*VEC_LANES + i] = v;
            end else if (en[i]) begin
                dataModel[row*VEC_LANES + i] = v;
            end
        end
        @(posedge clkIn);
        busWrite <= w;
    endtask

    task automatic stopWrites();
        @(posedge clkIn);
        busWrite.wrEn <= '0;
    endtask

    task automatic loadMatrix(input bit isFilt, input int numElems);
        for (int r = 0; r < (numElems + VEC_LANES - 1) / VEC_LANES; r++) begin
            writeWord(isFilt, r, '1);
        end
        stopWrites();
    endtask

    // Window sums in raster order that wrap at 32 bits
    function automatic void buildExpected(input dimsT d);
        int  outRows = int'(d.dataRows) - int'(d.filtRows) + 1;
        int  outCols = int'(d.dataCols) - int'(d.filtCols) + 1;
        accT sum;
        expQ.delete();
        for (int r = 0; r < outRows; r++) begin
            for (int c = 0; c < outCols; c++) begin
                sum = '0;
                for (int fr = 0; fr < int'(d.filtRows); fr++) begin
                    for (int fc = 0; fc < int'(d.filtCols); fc++) begin
                        sum += accT'(dataModel[(r + fr) * int'(d.dataCols) + c + fc]) *
                               accT'(filtModel[fr * int'(d.filtCols) + fc]);
                    end
                end
                expQ.push_back(sum);
            end
        end
    endfunction

    task automatic runConv(input dimsT d, input int readyPct);
        int  cycles;
        accT expVal;
        buildExpected(d);
        @(posedge clkIn);
        dims <= d;
        startIn <= 1'b1;
        @(posedge clkIn);
        startIn <= 1'b0;
        cycles = 0;
        while (expQ.size() > 0 && cycles < RUN_TIMEOUT) begin
            @(posedge clkIn);
            cycles++;
            if (validOut && readyIn) begin
                expVal = expQ.pop_front();
                assert (dataOut === expVal) else begin
                    $display("error: dataOut expected %h actual %h", expVal, dataOut);
                    testErrors++;
                end
            end
            readyIn <= (($urandom % 100) < readyPct);
        end
        if (expQ.size() > 0) begin
            $display("timed out with %0d results still missing after %0d cycles",
                     expQ.size(), cycles);
            testErrors++;
            timedOut = 1'b1;
        end else begin
            // Nothing may follow the last expected result
            readyIn <= 1'b1;
            repeat (QUIET_CYCLES) begin
                @(posedge clkIn);
                assert (!validOut) else begin
                    $display("an extra result appeared on dataOut after the run");
                    testErrors++;
                end
            end
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, testErrors);
            testsFailed++;
        end
        errors += testErrors;
        testErrors = 0;
    endtask

    initial begin
        dimsT d;
        void'($urandom(61684));
        rstIn = 1'b1;
        busWrite = '0;
        startIn = 1'b0;
        dims = '0;
        readyIn = 1'b0;
        repeat (5) @(posedge clkIn);
        rstIn <= 1'b0;

        // Idle output after reset
        readyIn <= 1'b1;
        repeat (10) begin
            @(posedge clkIn);
            assert (!validOut) else begin
                $display("error: validOut expected 0 actual %h", validOut);
                testErrors++;
            end
        end
        finishTest("test 1 idle after reset");

        loadMatrix(1'b0, 64);
        loadMatrix(1'b1, 12);
        d = '{filtRows: 3, filtCols: 4, dataRows: 8, dataCols: 8};
        runConv(d, 100);
        finishTest("test 2 8x8 data, 3x4 filter");

        if (!timedOut) begin
            // Five filter columns leave a three-lane masked tail
            loadMatrix(1'b0, 100);
            loadMatrix(1'b1, 15);
            d = '{filtRows: 3, filtCols: 5, dataRows: 10, dataCols: 10};
            runConv(d, 100);
            finishTest("test 3 10x10 data, 3x5 filter");
        end

        if (!timedOut) begin
            loadMatrix(1'b0, 256);
            loadMatrix(1'b1, 4);
            d = '{filtRows: 2, filtCols: 2, dataRows: 16, dataCols: 16};
            runConv(d, 30);
            finishTest("test 4 16x16 data, random readyIn");
        end

        if (!timedOut) begin
            // The 4x6 filter reaches rows that earlier runs never wrote
            loadMatrix(1'b1, 24);
            // Partial rewrites inside the areas the next run reads
            for (int i = 0; i < 24; i++) begin
                if (i % 2 == 1) begin
                    writeWord(1'b1, $urandom % 6, VEC_LANES'($urandom));
                end else begin
                    writeWord(1'b0, $urandom % 27, VEC_LANES'($urandom));
                end
            end
            stopWrites();
            d = '{filtRows: 4, filtCols: 6, dataRows: 12, dataCols: 9};
            runConv(d, 100);
            finishTest("test 5 partial write enables");
        end

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && !timedOut) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
